//--- tb/udp_echo_golden.txt
# src_ip dst_ip src_port dst_port beats seed stall verdict, one frame per line
# ips, ports and seed in hex; beats and stall in decimal; verdict is echo or drop
0a000001 c0a80180 c350 04d2 4 1a2b3c4d 0 echo
0a000002 c0a80180 c351 04d3 3 00000000 0 drop
0a000003 c0a80180 1f90 04d2 1 deadbeef 0 echo
0a000004 c0a80180 0035 0035 2 cafef00d 0 drop
0a000005 c0a80180 ea60 04d2 8 12345678 0 echo
0a000006 c0a80180 ea61 04d2 40 0badc0de 1 echo
0a000007 c0a80180 0400 0000 5 55aa55aa 0 drop
0a000008 c0a80180 9c40 04d2 2 a5a5a5a5 0 echo
ac100001 c0a80180 9c41 04d2 16 87654321 0 echo
ac100002 c0a80180 9c42 d204 6 13572468 1 drop
ac100003 c0a80180 9c43 04d2 30 fedcba98 1 echo
ac100004 c0a80180 1234 1234 1 00ff00ff 0 drop
ac100005 c0a80180 04d2 04d2 1 01020304 0 echo
c0a80101 c0a80180 7530 04d2 3 0f0f0f0f 0 echo
c0a80102 c0a80180 7531 04d1 12 f0f0f0f0 0 drop
c0a80103 c0a80180 7532 04d2 33 3c3c3c3c 1 echo
c0a80104 c0a80180 7533 ffff 4 c3c3c3c3 0 drop
c0a80105 c0a80180 7534 04d2 5 96969696 0 echo
c0a80106 0a0a0a0a 7535 04d2 2 69696969 0 echo
c0a80107 c0a80180 7536 04d2 32 00000001 1 echo
c0a80108 c0a80180 7537 0000 1 00000002 0 drop
c0a80109 c0a80180 7538 04d2 1 00000003 0 echo
c0a8010a c0a80180 7539 04d2 7 80000001 0 echo
c0a8010b c0a80180 753a 04d0 9 7ffffffe 1 drop
c0a8010c c0a80180 753b 04d2 1 00000006 0 echo

//--- verilog.f
hw/udp_echo_pkg.sv
hw/payload_fifo.sv
hw/first_byte_led.sv
hw/udp_echo_filter.sv
hw/udp_echo_core.sv
tb/tb_clock_gen.sv
tb/tb_udp_echo.sv

//--- run_sim.sh
#!/bin/sh
# Builds the UDP echo testbench with Verilator and runs it.
# The result is taken from the pass message in the simulation output.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f verilog.f --top-module tb_udp_echo -o sim_udp_echo; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_udp_echo)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi

//--- tb/tb_udp_echo.sv
/*
 * UDP echo core testbench
 * Sends the frames listed in the golden file, predicts reply headers and
 * echoed beats, and checks the tx streams, the LEDs and back-pressure.
 * A watchdog bounds the run from the total beat count.
 */

`timescale 1ns/1ps

module tb_udp_echo;

    localparam udp_echo_pkg::udp_port_t ECHO_PORT  = 16'd1234;
    localparam udp_echo_pkg::ip_addr_t  LOCAL_IP   = 32'hc0a8_0180;
    localparam int                      FIFO_DEPTH = 16;
    localparam int                      PERIOD_NS  = 4;

    // One line of the golden file
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] beats;
        logic [31:0] seed;
        logic        stall;
        logic        echo;
    } frame_t;

    logic                        clk;
    logic                        rst;
    logic                        rx_hdr_valid;
    logic                        rx_hdr_ready;
    udp_echo_pkg::udp_hdr_t      rx_hdr;
    logic                        rx_payload_valid;
    logic                        rx_payload_ready;
    udp_echo_pkg::payload_beat_t rx_payload;
    logic                        tx_hdr_valid;
    logic                        tx_hdr_ready;
    udp_echo_pkg::udp_hdr_t      tx_hdr;
    logic                        tx_payload_valid;
    logic                        tx_payload_ready;
    udp_echo_pkg::payload_beat_t tx_payload;
    logic [1:0]                  led_g;

    frame_t                      frames[$];
    udp_echo_pkg::udp_hdr_t      exp_hdr_q[$];
    udp_echo_pkg::payload_beat_t exp_beat_q[$];

    int         mismatch_count;
    int         failure_count;
    int         timeout_ns;
    logic       stall_mode;
    logic       drop_mode;
    logic       gaps_now;
    logic       saw_rx_stall;
    logic       prev_tx_valid;
    logic [1:0] exp_led;

    tb_clock_gen #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (3)
    ) u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    udp_echo_core #(
        .ECHO_PORT  (ECHO_PORT),
        .LOCAL_IP   (LOCAL_IP),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) UUT (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_hdr           (rx_hdr),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .rx_payload       (rx_payload),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_hdr           (tx_hdr),
        .tx_payload_valid (tx_payload_valid),
        .tx_payload_ready (tx_payload_ready),
        .tx_payload       (tx_payload),
        .led_g            (led_g)
    );

    // Payload word idx of a frame with a low byte that changes per beat
    function automatic udp_echo_pkg::payload_beat_t make_beat(logic [31:0] seed, int idx,
                                                              int beats);
        udp_echo_pkg::payload_beat_t b;
        logic [31:0]                 step;
        step   = seed + 32'(idx) * 32'h0101_0107;
        b.data = {seed ^ 32'(idx), step};
        b.keep = 8'hff;
        b.last = (idx == beats - 1);
        b.user = seed[idx % 32];
        return b;
    endfunction

    function automatic udp_echo_pkg::udp_hdr_t rx_header_of(frame_t f);
        udp_echo_pkg::udp_hdr_t h;
        h.source_ip   = f.src_ip;
        h.dest_ip     = f.dst_ip;
        h.source_port = f.src_port;
        h.dest_port   = f.dst_port;
        h.length      = 16'd8 + (f.beats << 3);
        h.checksum    = f.seed[31:16];
        h.ttl         = 8'd30;
        return h;
    endfunction

    // Reply header with swapped ports, sent from our address without checksum
    function automatic udp_echo_pkg::udp_hdr_t reply_header_of(frame_t f);
        udp_echo_pkg::udp_hdr_t h;
        h.source_ip   = LOCAL_IP;
        h.dest_ip     = f.src_ip;
        h.source_port = f.dst_port;
        h.dest_port   = f.src_port;
        h.length      = 16'd8 + (f.beats << 3);
        h.checksum    = 16'h0000;
        h.ttl         = 8'd64;
        return h;
    endfunction

    task automatic load_frames();
        int          fd;
        int          n;
        string       line;
        logic [31:0] sip;
        logic [31:0] dip;
        logic [31:0] seed;
        logic [15:0] sp;
        logic [15:0] dp;
        int          beats;
        int          stall;
        logic [31:0] verdict;
        frame_t      f;
        fd = $fopen("tb/udp_echo_golden.txt", "r");
        if (fd == 0) begin
            failure_count++;
            $display("Could not open the golden frame file");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %d %h %d %s", sip, dip, sp, dp, beats, seed,
                        stall, verdict);
            if (n != 8 || beats < 1) begin
                failure_count++;
                $display("Malformed golden line: %s", line);
                continue;
            end
            f = '{sip, dip, sp, dp, 16'(beats), seed, (stall != 0), (verdict == "echo")};
            // The stated verdict has to follow from the port rule
            assert (f.echo == (dp == ECHO_PORT)) else begin
                failure_count++;
                $display("Golden verdict for dest port %0d contradicts the echo port", dp);
            end
            frames.push_back(f);
        end
        $fclose(fd);
    endtask

    task automatic check_after_reset();
        assert (tx_hdr_valid == 1'b0 && tx_payload_valid == 1'b0) else begin
            mismatch_count++;
            $display("Mismatch at %0t: tx valid high after reset (hdr %b, payload %b)",
                     $time, tx_hdr_valid, tx_payload_valid);
        end
        assert (led_g == 2'b11) else begin
            mismatch_count++;
            $display("Mismatch at %0t: led_g %b after reset, expected 11", $time, led_g);
        end
    endtask

    task automatic send_frame(input frame_t f);
        int i;
        @(posedge clk);
        #1;
        if (f.echo) begin
            exp_hdr_q.push_back(reply_header_of(f));
            for (i = 0; i < int'(f.beats); i++) begin
                exp_beat_q.push_back(make_beat(f.seed, i, int'(f.beats)));
            end
        end
        stall_mode   = f.stall;
        drop_mode    = !f.echo;
        saw_rx_stall = 1'b0;
        rx_hdr       = rx_header_of(f);
        rx_hdr_valid = 1'b1;
        do @(posedge clk); while (!rx_hdr_ready);
        #1;
        rx_hdr_valid = 1'b0;
        for (i = 0; i < int'(f.beats); i++) begin
            rx_payload       = make_beat(f.seed, i, int'(f.beats));
            rx_payload_valid = 1'b1;
            do @(posedge clk); while (!rx_payload_ready);
            #1;
        end
        rx_payload_valid = 1'b0;
        stall_mode       = 1'b0;
        drop_mode        = 1'b0;
        if (f.stall && f.echo && f.beats > 16) begin
            assert (saw_rx_stall) else begin
                failure_count++;
                $display("rx_payload_ready never dropped while frame from port %0d stalled",
                         f.src_port);
            end
        end
        repeat (2) @(posedge clk);
    endtask

    // tx side ready with random gaps while a stall frame is active
    always @(posedge clk) begin
        gaps_now = stall_mode;
        #1;
        if (gaps_now) begin
            tx_hdr_ready     = ($urandom % 2) == 0;
            tx_payload_ready = ($urandom % 4) == 0;
        end else begin
            tx_hdr_ready     = 1'b1;
            tx_payload_ready = 1'b1;
        end
    end

    always @(posedge clk) begin : hdr_monitor
        udp_echo_pkg::udp_hdr_t exp_hdr;
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            assert (exp_hdr_q.size() != 0) else begin
                failure_count++;
                $display("Extra tx header at %0t to port %0d, no echo frame pending",
                         $time, tx_hdr.dest_port);
            end
            if (exp_hdr_q.size() != 0) begin
                exp_hdr = exp_hdr_q.pop_front();
                assert (tx_hdr == exp_hdr) else begin
                    mismatch_count++;
                    $display("Mismatch at %0t: tx header %h, expected %h", $time, tx_hdr,
                             exp_hdr);
                end
            end
        end
    end

    always @(posedge clk) begin : beat_monitor
        udp_echo_pkg::payload_beat_t exp_beat;
        if (!rst && tx_payload_valid && tx_payload_ready) begin
            assert (exp_beat_q.size() != 0) else begin
                failure_count++;
                $display("Extra tx payload beat at %0t, no echoed beat pending", $time);
            end
            if (exp_beat_q.size() != 0) begin
                exp_beat = exp_beat_q.pop_front();
                assert (tx_payload == exp_beat) else begin
                    mismatch_count++;
                    $display("Mismatch at %0t: tx beat %h, expected %h", $time, tx_payload,
                             exp_beat);
                end
            end
        end
        if (!rst && stall_mode && rx_payload_valid && !rx_payload_ready) begin
            saw_rx_stall = 1'b1;
        end
    end

    // Dropped frames are taken at full rate whatever the tx side does
    always @(posedge clk) begin : drop_monitor
        if (!rst && drop_mode) begin
            assert ((!rx_hdr_valid || rx_hdr_ready) &&
                    (!rx_payload_valid || rx_payload_ready)) else begin
                mismatch_count++;
                $display("Mismatch at %0t: drop frame stalled, hdr ready %b, payload ready %b",
                         $time, rx_hdr_ready, rx_payload_ready);
            end
        end
    end

    // LED model follows rises of the observed tx payload valid
    always @(posedge clk) begin : led_monitor
        if (rst) begin
            exp_led       = 2'b11;
            prev_tx_valid = 1'b0;
        end else begin
            assert (led_g == exp_led) else begin
                mismatch_count++;
                $display("Mismatch at %0t: led_g %b, expected %b", $time, led_g, exp_led);
            end
            if (tx_payload_valid && !prev_tx_valid) begin
                exp_led = ~tx_payload.data[1:0];
            end
            prev_tx_valid = tx_payload_valid;
        end
    end

    initial begin : watchdog
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("Timeout at %0t: %0d reply headers and %0d payload beats never arrived",
                 $time, exp_hdr_q.size(), exp_beat_q.size());
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : main
        int total_beats;
        rx_hdr_valid     = 1'b0;
        rx_hdr           = '0;
        rx_payload_valid = 1'b0;
        rx_payload       = '0;
        tx_hdr_ready     = 1'b0;
        tx_payload_ready = 1'b0;
        mismatch_count   = 0;
        failure_count    = 0;
        stall_mode       = 1'b0;
        drop_mode        = 1'b0;
        saw_rx_stall     = 1'b0;
        void'($urandom(32'h324a));
        load_frames();
        total_beats = 0;
        foreach (frames[k]) begin
            total_beats += int'(frames[k].beats);
        end
        timeout_ns = (total_beats * 50 + frames.size() * 20 + 200) * PERIOD_NS;
        @(negedge rst);
        @(posedge clk);
        check_after_reset();
        foreach (frames[k]) begin
            send_frame(frames[k]);
        end
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            @(posedge clk);
        end
        // Quiet period to catch anything extra
        repeat (20) @(posedge clk);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb/tb_clock_gen.sv
/*
 * Testbench clock and reset generator
 * Free running clock and a synchronous reset held for a few cycles
 */

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Released just after a rising edge so the DUT sees a clean level
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- hw/udp_echo_core.sv
/*
 * UDP echo core
 * Port-filtered UDP loopback. Frames for the echo port come back with a
 * swapped reply header and their payload buffered in a FIFO, others
 * are dropped. The first byte of each outgoing burst drives the LEDs.
 */

`timescale 1ns/1ps

module udp_echo_core #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT  = 16'd1234,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP   = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter int                      FIFO_DEPTH = 8192
) (
    input  logic                        clk,
    input  logic                        rst,

    // Received UDP frames
    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,
    input  udp_echo_pkg::udp_hdr_t      rx_hdr,
    input  logic                        rx_payload_valid,
    output logic                        rx_payload_ready,
    input  udp_echo_pkg::payload_beat_t rx_payload,

    // Reply UDP frames
    output logic                        tx_hdr_valid,
    input  logic                        tx_hdr_ready,
    output udp_echo_pkg::udp_hdr_t      tx_hdr,
    output logic                        tx_payload_valid,
    input  logic                        tx_payload_ready,
    output udp_echo_pkg::payload_beat_t tx_payload,

    output logic [1:0]                  led_g
);

    // Filter to FIFO payload stream
    logic                        fifo_valid;
    logic                        fifo_ready;
    udp_echo_pkg::payload_beat_t fifo_beat;

    udp_echo_filter #(
        .ECHO_PORT (ECHO_PORT),
        .LOCAL_IP  (LOCAL_IP)
    ) u_filter (
        .clk              (clk),
        .rst              (rst),
        .rx_hdr_valid     (rx_hdr_valid),
        .rx_hdr_ready     (rx_hdr_ready),
        .rx_hdr           (rx_hdr),
        .rx_payload_valid (rx_payload_valid),
        .rx_payload_ready (rx_payload_ready),
        .rx_payload       (rx_payload),
        .tx_hdr_valid     (tx_hdr_valid),
        .tx_hdr_ready     (tx_hdr_ready),
        .tx_hdr           (tx_hdr),
        .fifo_valid       (fifo_valid),
        .fifo_ready       (fifo_ready),
        .fifo_beat        (fifo_beat)
    );

    payload_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_payload_fifo (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (fifo_valid),
        .in_ready  (fifo_ready),
        .in_beat   (fifo_beat),
        .out_valid (tx_payload_valid),
        .out_ready (tx_payload_ready),
        .out_beat  (tx_payload)
    );

    // Watches the outgoing payload without ever stalling the stream
    first_byte_led u_led (
        .clk        (clk),
        .rst        (rst),
        .beat_valid (tx_payload_valid),
        .beat_data  (tx_payload.data),
        .led_g      (led_g)
    );

endmodule

//--- hw/udp_echo_filter.sv
/*
 * UDP echo port filter
 * Checks the destination port of each received header. Matching frames
 * get a reply header and their payload is passed to the payload FIFO,
 * all other frames are accepted and discarded.
 */

`timescale 1ns/1ps

module udp_echo_filter #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = 16'd1234,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP  = {8'd192, 8'd168, 8'd1, 8'd128}
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        rx_hdr_valid,
    output logic                        rx_hdr_ready,
    input  udp_echo_pkg::udp_hdr_t      rx_hdr,
    input  logic                        rx_payload_valid,
    output logic                        rx_payload_ready,
    input  udp_echo_pkg::payload_beat_t rx_payload,

    output logic                        tx_hdr_valid,
    input  logic                        tx_hdr_ready,
    output udp_echo_pkg::udp_hdr_t      tx_hdr,

    output logic                        fifo_valid,
    input  logic                        fifo_ready,
    output udp_echo_pkg::payload_beat_t fifo_beat
);

    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        DROP
    } state_t;

    state_t state;
    state_t state_next;
    logic   port_match;
    logic   hdr_xfer;
    logic   last_xfer;

    assign port_match = (rx_hdr.dest_port == ECHO_PORT);
    assign hdr_xfer   = (state == IDLE) && rx_hdr_valid && rx_hdr_ready;
    assign last_xfer  = rx_payload_valid && rx_payload_ready && rx_payload.last;

    // Verdict is taken once per frame and held in the state until the last beat
    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (hdr_xfer) begin
                    state_next = port_match ? FORWARD : DROP;
                end
            end
            FORWARD, DROP: begin
                if (last_xfer) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Handshake steering per state
    always_comb begin
        rx_hdr_ready     = 1'b0;
        tx_hdr_valid     = 1'b0;
        rx_payload_ready = 1'b0;
        fifo_valid       = 1'b0;
        case (state)
            IDLE: begin
                // Foreign ports are swallowed without waiting on the tx side
                rx_hdr_ready = port_match ? tx_hdr_ready : 1'b1;
                tx_hdr_valid = rx_hdr_valid && port_match;
            end
            FORWARD: begin
                rx_payload_ready = fifo_ready;
                fifo_valid       = rx_payload_valid;
            end
            DROP: begin
                rx_payload_ready = 1'b1;
            end
            default: begin
                rx_hdr_ready = 1'b0;
            end
        endcase
    end

    assign fifo_beat = rx_payload;

    // Reply goes back to the sender from our own address
    always_comb begin
        tx_hdr.source_ip   = LOCAL_IP;
        tx_hdr.dest_ip     = rx_hdr.source_ip;
        tx_hdr.source_port = rx_hdr.dest_port;
        tx_hdr.dest_port   = rx_hdr.source_port;
        tx_hdr.length      = rx_hdr.length;
        tx_hdr.checksum    = udp_echo_pkg::REPLY_CHECKSUM;
        tx_hdr.ttl         = udp_echo_pkg::REPLY_TTL;
    end

endmodule

//--- hw/first_byte_led.sv
/*
 * First byte LED display
 * Latches the low data byte whenever the watched stream turns valid
 * and shows its two low bits, inverted, on the green LEDs
 */

`timescale 1ns/1ps

module first_byte_led (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     beat_valid,
    input  udp_echo_pkg::beat_data_t beat_data,
    output logic [1:0]               led_g
);

    logic       valid_prev;
    logic [7:0] led_byte;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_prev <= 1'b0;
            led_byte   <= 8'h00;
        end else begin
            valid_prev <= beat_valid;
            // Rising valid marks the start of new output data
            if (beat_valid && !valid_prev) begin
                led_byte <= beat_data[7:0];
            end
        end
    end

    assign led_g = ~led_byte[1:0];

endmodule

//--- hw/payload_fifo.sv
/*
 * Payload FIFO
 * Synchronous circular buffer for payload beats with first-word-fall-through
 * output. Pointers carry one extra wrap bit to tell full from empty.
 */

`timescale 1ns/1ps

module payload_fifo #(
    parameter int DEPTH = 8192
) (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        in_valid,
    output logic                        in_ready,
    input  udp_echo_pkg::payload_beat_t in_beat,

    output logic                        out_valid,
    input  logic                        out_ready,
    output udp_echo_pkg::payload_beat_t out_beat
);

    // DEPTH is a power of two, at least 2
    localparam int ADDR_W = $clog2(DEPTH);

    typedef logic [ADDR_W:0] ptr_t;

    udp_echo_pkg::payload_beat_t mem [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    // Same index with opposite wrap bits means the buffer is full
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                   (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign in_ready  = !full;
    assign out_valid = !empty;

    assign wr_en = in_valid && !full;
    assign rd_en = out_ready && !empty;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_W-1:0]] <= in_beat;
        end
    end

    // Head of the queue is shown without waiting for a read
    assign out_beat = mem[rd_ptr[ADDR_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

//--- hw/udp_echo_pkg.sv
/*
 * UDP echo shared definitions
 * Field widths, the decoded UDP header and payload beat structs,
 * and the fixed values placed in every reply header
 */

package udp_echo_pkg;

    // Widths that carry a protocol meaning
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;
    typedef logic [7:0]  ttl_t;

    // Payload word and its byte enables
    typedef logic [63:0] beat_data_t;
    typedef logic [7:0]  beat_keep_t;

    // Decoded UDP header as handed over by the UDP/IP stack
    typedef struct packed {
        ip_addr_t    source_ip;
        ip_addr_t    dest_ip;
        udp_port_t   source_port;
        udp_port_t   dest_port;
        udp_len_t    length;
        logic [15:0] checksum;
        ttl_t        ttl;
    } udp_hdr_t;

    // One payload word with its sideband flags
    typedef struct packed {
        beat_data_t data;
        beat_keep_t keep;
        logic       last;
        logic       user;
    } payload_beat_t;

    // Reply header constants
    localparam ttl_t REPLY_TTL = 8'd64;

    // Zero tells the stack the checksum was not computed
    localparam logic [15:0] REPLY_CHECKSUM = 16'h0000;

endpackage
